//--- lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// byte address width, gives 1 KiB of data memory
`define ADDR_W 10

// bytes in one data word
`define WORD_BYTES 4

// bytes in one memory line
// a two-word window never reaches past the end of a line
`define LINE_BYTES 16

// number of words held by the memory
`define MEM_WORDS 256

// data word width in bits
`define WORD_W 32

`endif

//--- lsuPkg.sv
`include "lsu_settings.svh"

package lsuPkg;

  // byte address as issued by the core
  typedef logic [`ADDR_W-1:0] byteAddrT;

  // word index into the memory, byte offset dropped
  typedef logic [`ADDR_W-$clog2(`WORD_BYTES)-1:0] wordAddrT;

  // one data word
  typedef logic [`WORD_W-1:0] wordT;

  // eight-byte window, addressed word in the low half
  typedef logic [2*`WORD_W-1:0] windowT;

  // one enable per window byte lane
  typedef logic [2*`WORD_BYTES-1:0] laneMaskT;

  // byte offset within a word
  typedef logic [$clog2(`WORD_BYTES)-1:0] offsetT;

  // access size code, code 3 behaves as a word
  typedef logic [1:0] accessSizeT;

  localparam accessSizeT sizeByte = 2'd0;
  localparam accessSizeT sizeHalf = 2'd1;
  localparam accessSizeT sizeWord = 2'd2;

  // spill sequencer states
  typedef enum logic [1:0] {seqReady, seqSpill, seqStoreDelay} seqStateT;

endpackage

//--- lsuIfs.sv
`include "lsu_settings.svh"

//////////////////////////////////////////////////////////////////////
// beat information, one memory access per cycle
//////////////////////////////////////////////////////////////////////

interface beatIf;
  import lsuPkg::*;

  // a memory access happens this cycle
  logic       beatValid;
  logic       beatWrite;
  // second half of a line-crossing access
  logic       secondBeat;
  wordAddrT   beatWordAddr;
  offsetT     beatOffset;
  accessSizeT beatSize;
  // the access in flight spans two lines
  logic       splitAccess;

  // driven by the spill sequencer
  modport source (
    output beatValid, beatWrite, secondBeat, beatWordAddr,
    output beatOffset, beatSize, splitAccess
  );

  // read by the combiner and the load merger
  modport sink (
    input beatValid, beatWrite, secondBeat, beatWordAddr,
    input beatOffset, beatSize, splitAccess
  );

endinterface

//////////////////////////////////////////////////////////////////////
// window memory request and read data
//////////////////////////////////////////////////////////////////////

interface memIf;
  import lsuPkg::*;

  logic     memEn;
  logic     memWe;
  wordAddrT memWordAddr;
  windowT   memWData;
  laneMaskT memLaneMask;
  // read window, valid the cycle after memEn
  windowT   memRData;

  modport master (
    output memEn, memWe, memWordAddr, memWData, memLaneMask,
    input  memRData
  );

  modport slave (
    input  memEn, memWe, memWordAddr, memWData, memLaneMask,
    output memRData
  );

endinterface

//--- spillSequencer.sv
`include "lsu_settings.svh"

module spillSequencer (
  input  logic               clk,
  input  logic               rstN,
  input  logic               req,
  input  logic               write,
  input  lsuPkg::accessSizeT size,
  input  lsuPkg::byteAddrT   addr,
  output logic               busy,
  beatIf.source              beat
);
  import lsuPkg::*;

  localparam int lineOffW = $clog2(`LINE_BYTES);
  localparam int wordOffW = $clog2(`WORD_BYTES);

  seqStateT          state;
  seqStateT          nextState;
  logic [2:0]        accessLen;
  logic [lineOffW:0] spanEnd;
  logic              crossesLine;
  logic              startSplit;
  wordAddrT          heldWordAddr;
  offsetT            heldOffset;
  accessSizeT        heldSize;
  logic              heldWrite;

  //////////////////////////////////////////////////////////////////////
  // line crossing detect
  //////////////////////////////////////////////////////////////////////

  // access length in bytes
  always_comb begin
    case (size)
      sizeByte: accessLen = 3'd1;
      sizeHalf: accessLen = 3'd2;
      default:  accessLen = 3'd4;
    endcase
  end

  // one past the last byte touched, measured from the line start
  assign spanEnd = {1'b0, addr[lineOffW-1:0]} + {{(lineOffW-2){1'b0}}, accessLen};
  assign crossesLine = (spanEnd > `LINE_BYTES);

  // only a request seen while idle can start a split
  assign startSplit = (state == seqReady) && req && crossesLine;

  //////////////////////////////////////////////////////////////////////
  // beat FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= seqReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      seqReady: begin
        // stores wait out the first write, loads go fetch the next line
        if (startSplit) begin
          nextState = write ? seqStoreDelay : seqSpill;
        end
      end
      seqSpill:      nextState = seqReady;
      seqStoreDelay: nextState = seqReady;
      default:       nextState = seqReady;
    endcase
  end

  // second beat starts on the first word of the following line
  always_ff @(posedge clk) begin
    if (startSplit) begin
      heldWordAddr <= wordAddrT'(addr[`ADDR_W-1:wordOffW]) + 1'b1;
      heldOffset   <= addr[wordOffW-1:0];
      heldSize     <= size;
      heldWrite    <= write;
    end
  end

  // any state other than ready is the second beat
  assign busy = (state != seqReady);

  // first beat straight from the request, second beat from the held copy
  always_comb begin
    if (busy) begin
      beat.beatValid    = 1'b1;
      beat.beatWrite    = heldWrite;
      beat.secondBeat   = 1'b1;
      beat.beatWordAddr = heldWordAddr;
      beat.beatOffset   = heldOffset;
      beat.beatSize     = heldSize;
      beat.splitAccess  = 1'b1;
    end else begin
      beat.beatValid    = req;
      beat.beatWrite    = write;
      beat.secondBeat   = 1'b0;
      beat.beatWordAddr = addr[`ADDR_W-1:wordOffW];
      beat.beatOffset   = addr[wordOffW-1:0];
      beat.beatSize     = size;
      beat.splitAccess  = crossesLine;
    end
  end

endmodule

//--- storeAligner.sv
`include "lsu_settings.svh"

module storeAligner (
  input  logic               clk,
  input  logic               holdLanes,
  input  lsuPkg::wordT       wdata,
  input  lsuPkg::accessSizeT size,
  input  lsuPkg::offsetT     offset,
  output lsuPkg::windowT     laneData,
  output lsuPkg::laneMaskT   laneMask
);
  import lsuPkg::*;

  localparam int byteW = `WORD_W / `WORD_BYTES;

  logic [3*`WORD_W-1:0] repWord;
  windowT               liveData;
  windowT               savedData;
  laneMaskT             baseMask;
  laneMaskT             liveMask;
  laneMaskT             savedMask;

  // three copies so the lanes never fill with zeros
  assign repWord = {wdata, wdata, wdata} << (byteW * offset);
  assign liveData = repWord[3*`WORD_W-1:`WORD_W];

  // enables before the offset shift
  always_comb begin
    case (size)
      sizeByte: baseMask = laneMaskT'(4'b0001);
      sizeHalf: baseMask = laneMaskT'(4'b0011);
      default:  baseMask = laneMaskT'(4'b1111);
    endcase
  end

  assign liveMask = baseMask << offset;

  // keep the request's lanes for the next cycle
  // the second beat of a split store reads them from here
  always_ff @(posedge clk) begin
    if (!holdLanes) begin
      savedData <= liveData;
      savedMask <= liveMask;
    end
  end

  assign laneData = holdLanes ? savedData : liveData;
  assign laneMask = holdLanes ? savedMask : liveMask;

endmodule

//--- accessCombiner.sv
`include "lsu_settings.svh"

module accessCombiner (
  beatIf.sink              beat,
  input  lsuPkg::windowT   laneData,
  input  lsuPkg::laneMaskT laneMask,
  memIf.master             mem
);
  import lsuPkg::*;

  localparam int halfLanes = `WORD_BYTES;

  windowT   beatData;
  laneMaskT beatMask;

  //////////////////////////////////////////////////////////////////////
  // lane select per beat
  //////////////////////////////////////////////////////////////////////

  // second beat writes the spilled upper lanes into the next line's first word
  always_comb begin
    if (beat.secondBeat) begin
      beatData = {laneData[2*`WORD_W-1:`WORD_W], laneData[2*`WORD_W-1:`WORD_W]};
      beatMask = {{halfLanes{1'b0}}, laneMask[2*halfLanes-1:halfLanes]};
    end else begin
      // first or only beat, lanes as aligned
      beatData = laneData;
      beatMask = laneMask;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory request
  //////////////////////////////////////////////////////////////////////

  assign mem.memEn       = beat.beatValid;
  assign mem.memWe       = beat.beatValid & beat.beatWrite;
  assign mem.memWordAddr = beat.beatWordAddr;
  assign mem.memWData    = beatData;
  // loads never enable a lane
  assign mem.memLaneMask = beatMask & {(2*halfLanes){beat.beatWrite}};

endmodule

//--- windowMem.sv
`include "lsu_settings.svh"

module windowMem (
  input logic clk,
  input logic rstN,
  memIf.slave mem
);
  import lsuPkg::*;

  localparam int lineWordBits = $clog2(`LINE_BYTES / `WORD_BYTES);
  localparam int byteW = `WORD_W / `WORD_BYTES;

  wordT                   memArray [`MEM_WORDS];
  wordAddrT               nextWordAddr;
  logic                   lineEnd;
  logic [`WORD_BYTES-1:0] lowMask;
  logic [`WORD_BYTES-1:0] highMask;
  wordT                   upperWord;

  assign nextWordAddr = mem.memWordAddr + 1'b1;

  // last word of a line, the window stops here
  assign lineEnd = &mem.memWordAddr[lineWordBits-1:0];

  assign lowMask  = mem.memLaneMask[`WORD_BYTES-1:0];
  // upper lanes would land in the next line
  assign highMask = lineEnd ? '0 : mem.memLaneMask[2*`WORD_BYTES-1:`WORD_BYTES];

  //////////////////////////////////////////////////////////////////////
  // masked window write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (mem.memWe) begin
      for (int i = 0; i < `WORD_BYTES; i++) begin
        if (lowMask[i]) begin
          memArray[mem.memWordAddr][i*byteW +: byteW] <= mem.memWData[i*byteW +: byteW];
        end
        if (highMask[i]) begin
          memArray[nextWordAddr][i*byteW +: byteW] <=
            mem.memWData[`WORD_W + i*byteW +: byteW];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registered window read
  //////////////////////////////////////////////////////////////////////

  // next word reads as zero past the line end
  assign upperWord = lineEnd ? '0 : memArray[nextWordAddr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mem.memRData <= '0;
    end else if (mem.memEn) begin
      mem.memRData <= {upperWord, memArray[mem.memWordAddr]};
    end
  end

endmodule

//--- loadMerge.sv
`include "lsu_settings.svh"

module loadMerge (
  input  logic           clk,
  input  logic           rstN,
  beatIf.sink            beat,
  input  lsuPkg::windowT memRData,
  output lsuPkg::wordT   rdata,
  output logic           done
);
  import lsuPkg::*;

  localparam int byteW = `WORD_W / `WORD_BYTES;

  logic       finalBeat;
  logic       prevValid;
  logic       prevWrite;
  logic       prevSecond;
  logic       prevSplit;
  offsetT     prevOffset;
  accessSizeT prevSize;
  wordT       firstLow;
  windowT     mergedWin;
  windowT     shiftedWin;
  wordT       sizeMask;

  // last beat of any access
  assign finalBeat = beat.beatValid & (~beat.splitAccess | beat.secondBeat);

  //////////////////////////////////////////////////////////////////////
  // beat info delayed to line up with the read window
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      prevValid  <= 1'b0;
      prevWrite  <= 1'b0;
      prevSecond <= 1'b0;
      prevSplit  <= 1'b0;
      done       <= 1'b0;
    end else begin
      prevValid  <= beat.beatValid;
      prevWrite  <= beat.beatWrite;
      prevSecond <= beat.secondBeat;
      prevSplit  <= beat.splitAccess;
      // pulses for stores as well
      done       <= finalBeat;
    end
  end

  always_ff @(posedge clk) begin
    prevOffset <= beat.beatOffset;
    prevSize   <= beat.beatSize;
    // low word of a split load's first window is the end of the first line
    if (prevValid && prevSplit && !prevSecond && !prevWrite) begin
      firstLow <= memRData[`WORD_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // merge, shift and zero-extend
  //////////////////////////////////////////////////////////////////////

  assign mergedWin  = prevSecond ? {memRData[`WORD_W-1:0], firstLow} : memRData;
  assign shiftedWin = mergedWin >> (byteW * prevOffset);

  always_comb begin
    case (prevSize)
      sizeByte: sizeMask = {{(`WORD_W-byteW){1'b0}}, {byteW{1'b1}}};
      sizeHalf: sizeMask = {{(`WORD_W-2*byteW){1'b0}}, {(2*byteW){1'b1}}};
      // word and code 3 both load a full word
      default:  sizeMask = '1;
    endcase
  end

  // valid in the done cycle
  assign rdata = shiftedWin[`WORD_W-1:0] & sizeMask;

endmodule

//--- lsuAlignTop.sv
`include "lsu_settings.svh"

module lsuAlignTop (
  input  logic               clk,
  input  logic               rstN,
  input  logic               req,
  input  logic               write,
  input  lsuPkg::accessSizeT size,
  input  lsuPkg::byteAddrT   addr,
  input  lsuPkg::wordT       wdata,
  output lsuPkg::wordT       rdata,
  output logic               done,
  output logic               busy
);
  import lsuPkg::*;

  windowT   laneData;
  laneMaskT laneMask;
  offsetT   reqOffset;

  beatIf beatBus ();
  memIf  memBus ();

  // byte offset of the incoming request within its word
  assign reqOffset = addr[$bits(offsetT)-1:0];

  //////////////////////////////////////////////////////////////////////
  // request side, sequencer and store lanes in parallel
  //////////////////////////////////////////////////////////////////////

  spillSequencer seq (
    .clk  (clk),
    .rstN (rstN),
    .req  (req),
    .write(write),
    .size (size),
    .addr (addr),
    .busy (busy),
    .beat (beatBus.source)
  );

  // lanes held through the second beat of a split store
  storeAligner aligner (
    .clk      (clk),
    .holdLanes(beatBus.secondBeat),
    .wdata    (wdata),
    .size     (size),
    .offset   (reqOffset),
    .laneData (laneData),
    .laneMask (laneMask)
  );

  accessCombiner combiner (
    .beat    (beatBus.sink),
    .laneData(laneData),
    .laneMask(laneMask),
    .mem     (memBus.master)
  );

  //////////////////////////////////////////////////////////////////////
  // memory and load return
  //////////////////////////////////////////////////////////////////////

  windowMem mem (
    .clk (clk),
    .rstN(rstN),
    .mem (memBus.slave)
  );

  loadMerge merger (
    .clk     (clk),
    .rstN    (rstN),
    .beat    (beatBus.sink),
    .memRData(memBus.memRData),
    .rdata   (rdata),
    .done    (done)
  );

endmodule

//--- tbClock.sv
module tbClock #(
  parameter int period      = 40,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic rstN
);

  // free running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held over the first few rising edges
  // release lands just after an edge, like the other inputs
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #5 rstN = 1'b1;
  end

endmodule

//--- lsuAlignTb.sv
`include "lsu_settings.svh"

module lsuAlignTb;
  import lsuPkg::*;

  localparam int period     = 40;
  localparam int driveDelay = 5;
  // fill, directed, random and sweep accesses
  localparam int accessCount = 2 * `MEM_WORDS + 100;
  // no access may take more than four cycles
  localparam int watchdogCycles = accessCount * 4 + 100;
  localparam int doneLimit      = 8;

  logic       clk;
  logic       rstN;
  logic       req;
  logic       write;
  accessSizeT size;
  byteAddrT   addr;
  wordT       wdata;
  wordT       rdata;
  logic       done;
  logic       busy;

  // byte-wide reference copy of the data memory
  logic [7:0]  model [1 << `ADDR_W];
  logic [31:0] lfsrState;
  int          errorCount;
  int          checkCount;

  tbClock #(.period(period), .resetCycles(3)) clkGen (.clk(clk), .rstN(rstN));

  lsuAlignTop DUT (
    .clk  (clk),
    .rstN (rstN),
    .req  (req),
    .write(write),
    .size (size),
    .addr (addr),
    .wdata(wdata),
    .rdata(rdata),
    .done (done),
    .busy (busy)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
  endtask

  function automatic int sizeBytes(input accessSizeT sz);
    case (sz)
      2'd0:    return 1;
      2'd1:    return 2;
      default: return 4;
    endcase
  endfunction

  // last touched byte past the end of its line
  function automatic bit isSplit(input byteAddrT a, input accessSizeT sz);
    return (int'(a % `LINE_BYTES) + sizeBytes(sz)) > `LINE_BYTES;
  endfunction

  // zero-extended little-endian read of the model
  function automatic wordT modelRead(input byteAddrT a, input accessSizeT sz);
    wordT     v;
    byteAddrT b;
    v = '0;
    for (int k = 0; k < sizeBytes(sz); k++) begin
      b = a + byteAddrT'(k);
      v[8*k +: 8] = model[b];
    end
    return v;
  endfunction

  function automatic void modelWrite(input byteAddrT a, input accessSizeT sz, input wordT d);
    byteAddrT b;
    for (int k = 0; k < sizeBytes(sz); k++) begin
      b = a + byteAddrT'(k);
      model[b] = d[8*k +: 8];
    end
  endfunction

  // every byte differs with the word index
  function automatic wordT fillWord(input wordAddrT w);
    return {w, ~w, w ^ 8'h5a, w + 8'h11};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // one access with timing and data checks
  //////////////////////////////////////////////////////////////////////

  task automatic runAccess(input logic wr, input accessSizeT sz, input byteAddrT a,
                           input wordT wd, input bit poke);
    int   cycle;
    int   doneCycle;
    int   busyCycles;
    int   expDone;
    bit   split;
    wordT expData;
    wordT got;
    split     = isSplit(a, sz);
    expDone   = split ? 2 : 1;
    expData   = modelRead(a, sz);
    got       = 'x;
    doneCycle = -1;
    busyCycles = 0;
    @(posedge clk);
    #driveDelay;
    req   = 1'b1;
    write = wr;
    size  = sz;
    addr  = a;
    wdata = wd;
    for (cycle = 0; cycle <= doneLimit && doneCycle < 0; cycle++) begin
      if (cycle > 0) begin
        @(posedge clk);
        #driveDelay;
        // a store request while busy must be dropped by the DUT
        if (cycle == 1 && poke && busy) begin
          req   = 1'b1;
          write = 1'b1;
          addr  = {~a[`ADDR_W-1], a[`ADDR_W-2:0]};
          wdata = ~wd;
        end else begin
          req = 1'b0;
        end
      end
      @(negedge clk);
      if (busy) busyCycles++;
      if (done) begin
        doneCycle = cycle;
        got = rdata;
      end
    end
    if (req) begin
      @(posedge clk);
      #driveDelay;
      req = 1'b0;
    end
    checkCount++;
    if (doneCycle < 0) begin
      $display("no done pulse for the access at addr %h", a);
      errorCount++;
    end else begin
      if (doneCycle != expDone) begin
        $display("done came %0d cycles after req instead of %0d, addr %h",
                 doneCycle, expDone, a);
        errorCount++;
      end
      if (busyCycles != expDone - 1) begin
        $display("busy was high for %0d cycles instead of %0d, addr %h",
                 busyCycles, expDone - 1, a);
        errorCount++;
      end
      if (!wr && got !== expData) begin
        $display("** Error: rdata expected %h got %h, addr %h size %0d",
                 expData, got, a, sz);
        errorCount++;
      end
    end
    if (wr) modelWrite(a, sz, wd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic checkReset();
    @(negedge clk);
    checkCount++;
    if (done !== 1'b0) begin
      $display("** Error: done expected %h got %h after reset", 1'b0, done);
      errorCount++;
    end
    if (busy !== 1'b0) begin
      $display("** Error: busy expected %h got %h after reset", 1'b0, busy);
      errorCount++;
    end
    if (DUT.memBus.memEn !== 1'b0) begin
      $display("** Error: memEn expected %h got %h after reset", 1'b0, DUT.memBus.memEn);
      errorCount++;
    end
    if (DUT.memBus.memWe !== 1'b0) begin
      $display("** Error: memWe expected %h got %h after reset", 1'b0, DUT.memBus.memWe);
      errorCount++;
    end
  endtask

  // aligned word stores so that no read ever returns unknown data
  task automatic fillMemory();
    for (int w = 0; w < `MEM_WORDS; w++) begin
      runAccess(1'b1, sizeWord, byteAddrT'(w * `WORD_BYTES), fillWord(wordAddrT'(w)), 1'b0);
    end
  endtask

  task automatic alignedWordTest();
    runAccess(1'b1, sizeWord, 10'h040, 32'h1234_5678, 1'b0);
    runAccess(1'b0, sizeWord, 10'h040, '0, 1'b0);
    runAccess(1'b1, sizeWord, 10'h3fc, 32'h8765_4321, 1'b0);
    runAccess(1'b0, sizeWord, 10'h3fc, '0, 1'b0);
  endtask

  // offsets that stay inside one line
  task automatic inLineTest();
    runAccess(1'b1, sizeHalf, 10'h081, 32'h0000_beef, 1'b0);
    runAccess(1'b1, sizeWord, 10'h085, 32'ha1b2_c3d4, 1'b0);
    runAccess(1'b1, sizeWord, 10'h08b, 32'h0f1e_2d3c, 1'b0);
    runAccess(1'b0, sizeWord, 10'h083, '0, 1'b0);
    runAccess(1'b0, sizeHalf, 10'h086, '0, 1'b0);
    runAccess(1'b0, sizeWord, 10'h08b, '0, 1'b0);
    runAccess(1'b0, sizeHalf, 10'h08e, '0, 1'b0);
    // neighbors read back as whole words
    for (int w = 0; w < 4; w++) begin
      runAccess(1'b0, sizeWord, byteAddrT'(10'h080 + 4 * w), '0, 1'b0);
    end
  endtask

  task automatic splitStoreTest();
    byteAddrT a;
    for (int off = 13; off <= 15; off++) begin
      a = byteAddrT'(10'h100 + 16 * (off - 13) + off);
      runAccess(1'b1, sizeWord, a, 32'h5500_00aa ^ off, 1'b1);
      // words on both sides of the boundary
      runAccess(1'b0, sizeWord, a & ~byteAddrT'(3), '0, 1'b0);
      runAccess(1'b0, sizeWord, (a & ~byteAddrT'(3)) + 4, '0, 1'b0);
    end
  endtask

  task automatic splitLoadTest();
    runAccess(1'b0, sizeWord, 10'h20d, '0, 1'b1);
    runAccess(1'b0, sizeWord, 10'h21e, '0, 1'b1);
    runAccess(1'b0, sizeWord, 10'h22f, '0, 1'b1);
    runAccess(1'b0, sizeHalf, 10'h23f, '0, 1'b1);
    // crosses the top of memory into word zero
    runAccess(1'b0, sizeWord, 10'h3fe, '0, 1'b1);
  endtask

  // upper store data must never reach memory
  task automatic narrowTest();
    runAccess(1'b1, sizeByte, 10'h2c1, 32'hdead_bea5, 1'b0);
    runAccess(1'b1, sizeHalf, 10'h2c6, 32'h1357_8001, 1'b0);
    runAccess(1'b1, sizeByte, 10'h2cf, 32'h0000_00f0, 1'b0);
    runAccess(1'b1, sizeHalf, 10'h2df, 32'hffff_9abc, 1'b1);
    runAccess(1'b0, sizeByte, 10'h2c1, '0, 1'b0);
    runAccess(1'b0, sizeByte, 10'h2cf, '0, 1'b0);
    runAccess(1'b0, sizeHalf, 10'h2c6, '0, 1'b0);
    runAccess(1'b0, sizeHalf, 10'h2df, '0, 1'b0);
    runAccess(1'b0, sizeWord, 10'h2c0, '0, 1'b0);
    runAccess(1'b0, sizeWord, 10'h2c4, '0, 1'b0);
    runAccess(1'b0, sizeWord, 10'h2cc, '0, 1'b0);
    runAccess(1'b0, sizeWord, 10'h2e0, '0, 1'b0);
  endtask

  // random mix where split accesses get a stray request while busy
  task automatic randomTest();
    logic [31:0] dirBits;
    logic [31:0] sizeBits;
    logic [31:0] addrBits;
    logic [31:0] dataBits;
    for (int i = 0; i < 40; i++) begin
      takeBits(1, dirBits);
      takeBits(2, sizeBits);
      takeBits(`ADDR_W, addrBits);
      takeBits(32, dataBits);
      runAccess(dirBits[0], accessSizeT'(sizeBits), byteAddrT'(addrBits), dataBits, 1'b1);
    end
  endtask

  // whole memory compared with the model to catch any stray write
  task automatic finalSweep();
    for (int w = 0; w < `MEM_WORDS; w++) begin
      runAccess(1'b0, sizeWord, byteAddrT'(w * `WORD_BYTES), '0, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    req        = 1'b0;
    write      = 1'b0;
    size       = sizeByte;
    addr       = '0;
    wdata      = '0;
    lfsrState  = 32'd32;
    errorCount = 0;
    checkCount = 0;
    wait (rstN === 1'b1);
    checkReset();
    fillMemory();
    alignedWordTest();
    inLineTest();
    splitStoreTest();
    splitLoadTest();
    narrowTest();
    randomTest();
    finalSweep();
    $display("accesses checked %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * period);
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+.
lsuPkg.sv
lsuIfs.sv
spillSequencer.sv
storeAligner.sv
accessCombiner.sv
windowMem.sv
loadMerge.sv
lsuAlignTop.sv
tbClock.sv
lsuAlignTb.sv
